// ==== procPkg.sv ====
// shared types for the three-stage 16-bit pipeline
// word and register-index types, opcodes, ALU operations, instruction fields
`default_nettype none

package procPkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIdx_t;

   // codes 8 to 14 are illegal
   typedef enum logic [3:0] {
      opNop  = 4'd0,
      opAdd  = 4'd1,
      opSub  = 4'd2,
      opAnd  = 4'd3,
      opXor  = 4'd4,
      opAddi = 4'd5,
      opLbi  = 4'd6,
      opSll  = 4'd7,
      opHalt = 4'd15
   } opcode_t;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluXor,
      aluSll,
      aluPassB
   } aluOp_t;

   // instruction field positions
   localparam int OpcodeHi = 15;
   localparam int OpcodeLo = 12;
   localparam int RdHi     = 11;
   localparam int RdLo     = 9;
   localparam int RsHi     = 8;
   localparam int RsLo     = 6;
   localparam int RtHi     = 5;
   localparam int RtLo     = 3;
   localparam int Imm6Hi   = 5;
   localparam int Imm6Lo   = 0;
   localparam int Imm8Hi   = 7;
   localparam int Imm8Lo   = 0;

endpackage

`default_nettype wire

// ==== regFile.sv ====
// register file with eight 16-bit registers
// two combinational read ports, one write port, same-cycle write bypass
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic            clk,
   input  logic            arstN,
   input  procPkg::regIdx_t rdRegA,
   input  procPkg::regIdx_t rdRegB,
   input  logic            wEn,
   input  procPkg::regIdx_t wReg,
   input  procPkg::word_t  wData,
   output procPkg::word_t  rdDataA,
   output procPkg::word_t  rdDataB
);

   procPkg::word_t regs [8];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wEn) begin
         regs[wReg] <= wData;
      end
   end

   // a read of the register being written sees the new value
   assign rdDataA = (wEn && (wReg == rdRegA)) ? wData : regs[rdRegA];
   assign rdDataB = (wEn && (wReg == rdRegB)) ? wData : regs[rdRegB];

endmodule

`default_nettype wire

// ==== decode.sv ====
// decode stage
// checks the opcode, reads the register file and registers the execute inputs;
// tracks the sticky error flag and drops everything after a HALT
`timescale 1ns/1ps
`default_nettype none

module decode (
   input  logic             clk,
   input  logic             arstN,
   input  logic             instrValid,
   input  procPkg::word_t   instr,
   input  logic             wEn,
   input  procPkg::regIdx_t wReg,
   input  procPkg::word_t   wData,
   output logic             xValid,
   output procPkg::aluOp_t  xOp,
   output procPkg::word_t   xA,
   output procPkg::word_t   xB,
   output procPkg::regIdx_t xSrcA,
   output procPkg::regIdx_t xSrcB,
   output logic             xUsesA,
   output logic             xUsesB,
   output procPkg::word_t   xImm,
   output logic             xUseImm,
   output logic             xRegWrt,
   output procPkg::regIdx_t xRd,
   output logic             xHalt,
   output logic             err
);

   procPkg::opcode_t opcode;
   procPkg::regIdx_t rd, rs, rt;
   procPkg::word_t   imm6Ext, imm8Ext, imm, rdDataA, rdDataB;
   procPkg::aluOp_t  op;
   logic             legal, usesA, usesB, useImm, regWrt, isHalt;
   logic             stopped, accept;

   assign opcode  = procPkg::opcode_t'(instr[procPkg::OpcodeHi:procPkg::OpcodeLo]);
   assign rd      = instr[procPkg::RdHi:procPkg::RdLo];
   assign rs      = instr[procPkg::RsHi:procPkg::RsLo];
   assign rt      = instr[procPkg::RtHi:procPkg::RtLo];
   assign imm6Ext = {{10{instr[procPkg::Imm6Hi]}}, instr[procPkg::Imm6Hi:procPkg::Imm6Lo]};
   assign imm8Ext = {{8{instr[procPkg::Imm8Hi]}}, instr[procPkg::Imm8Hi:procPkg::Imm8Lo]};

   regFile regs (
      .clk     (clk),
      .arstN   (arstN),
      .rdRegA  (rs),
      .rdRegB  (rt),
      .wEn     (wEn),
      .wReg    (wReg),
      .wData   (wData),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB)
   );

   always_comb begin
      legal  = 1'b1;
      op     = procPkg::aluAdd;
      usesA  = 1'b0;
      usesB  = 1'b0;
      useImm = 1'b0;
      regWrt = 1'b0;
      isHalt = 1'b0;
      imm    = imm6Ext;
      case (opcode)
         procPkg::opNop:  ;
         procPkg::opAdd: begin
            op    = procPkg::aluAdd;
            usesA = 1'b1;
            usesB = 1'b1;
         end
         procPkg::opSub: begin
            op    = procPkg::aluSub;
            usesA = 1'b1;
            usesB = 1'b1;
         end
         procPkg::opAnd: begin
            op    = procPkg::aluAnd;
            usesA = 1'b1;
            usesB = 1'b1;
         end
         procPkg::opXor: begin
            op    = procPkg::aluXor;
            usesA = 1'b1;
            usesB = 1'b1;
         end
         procPkg::opSll: begin
            op    = procPkg::aluSll;
            usesA = 1'b1;
            usesB = 1'b1;
         end
         procPkg::opAddi: begin
            op     = procPkg::aluAdd;
            usesA  = 1'b1;
            useImm = 1'b1;
         end
         procPkg::opLbi: begin
            op     = procPkg::aluPassB;
            useImm = 1'b1;
            imm    = imm8Ext;
         end
         procPkg::opHalt: isHalt = 1'b1;
         default:         legal = 1'b0;
      endcase
      // every legal opcode other than NOP and HALT writes rd
      regWrt = legal && (opcode != procPkg::opNop) && !isHalt;
   end

   // nothing is taken once a HALT has gone through
   assign accept = instrValid && !stopped;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         xValid  <= 1'b0;
         xRegWrt <= 1'b0;
         xHalt   <= 1'b0;
         stopped <= 1'b0;
         err     <= 1'b0;
      end else begin
         xValid  <= accept && legal;
         xRegWrt <= accept && regWrt;
         xHalt   <= accept && isHalt;
         stopped <= stopped || (accept && isHalt);
         err     <= err || (accept && !legal);
      end
   end

   always_ff @(posedge clk) begin
      xOp     <= op;
      xA      <= rdDataA;
      xB      <= rdDataB;
      xSrcA   <= rs;
      xSrcB   <= rt;
      xUsesA  <= usesA;
      xUsesB  <= usesB;
      xImm    <= imm;
      xUseImm <= useImm;
      xRd     <= rd;
   end

   // opcodes 8 to 14 set err and never reach execute
   assert property (@(posedge clk) disable iff (!arstN)
      accept && (opcode >= 4'd8) && (opcode != procPkg::opHalt) |=> err && !xValid);

endmodule

`default_nettype wire

// ==== execute.sv ====
// execute stage
// picks operands with forwarding, runs the ALU and registers the result
`timescale 1ns/1ps
`default_nettype none

module execute (
   input  logic             clk,
   input  logic             arstN,
   input  logic             xValid,
   input  procPkg::aluOp_t  xOp,
   input  procPkg::word_t   xA,
   input  procPkg::word_t   xB,
   input  procPkg::regIdx_t xSrcA,
   input  procPkg::regIdx_t xSrcB,
   input  logic             xUsesA,
   input  logic             xUsesB,
   input  procPkg::word_t   xImm,
   input  logic             xUseImm,
   input  logic             xRegWrt,
   input  procPkg::regIdx_t xRd,
   input  logic             xHalt,
   input  logic             fwdEn,
   input  procPkg::regIdx_t fwdReg,
   input  procPkg::word_t   fwdData,
   output logic             rValid,
   output logic             rRegWrt,
   output procPkg::regIdx_t rRd,
   output procPkg::word_t   rData,
   output logic             rHalt
);

   procPkg::word_t opA, opB, aluRes;
   logic           nearA, nearB, farA, farB;

   // the previous instruction still sits in our own output register,
   // the one before it sits in the result stage
   assign nearA = xUsesA && rValid && rRegWrt && (rRd == xSrcA);
   assign nearB = xUsesB && rValid && rRegWrt && (rRd == xSrcB);
   assign farA  = xUsesA && fwdEn && (fwdReg == xSrcA);
   assign farB  = xUsesB && fwdEn && (fwdReg == xSrcB);

   always_comb begin
      if (nearA) begin
         opA = rData;
      end else if (farA) begin
         opA = fwdData;
      end else begin
         opA = xA;
      end

      if (xUseImm) begin
         opB = xImm;
      end else if (nearB) begin
         opB = rData;
      end else if (farB) begin
         opB = fwdData;
      end else begin
         opB = xB;
      end
   end

   always_comb begin
      case (xOp)
         procPkg::aluAdd:   aluRes = opA + opB;
         procPkg::aluSub:   aluRes = opA - opB;
         procPkg::aluAnd:   aluRes = opA & opB;
         procPkg::aluXor:   aluRes = opA ^ opB;
         procPkg::aluSll:   aluRes = opA << opB[3:0];
         procPkg::aluPassB: aluRes = opB;
         default:           aluRes = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         rValid  <= 1'b0;
         rRegWrt <= 1'b0;
         rHalt   <= 1'b0;
      end else begin
         rValid  <= xValid;
         rRegWrt <= xValid && xRegWrt;
         rHalt   <= xValid && xHalt;
      end
   end

   always_ff @(posedge clk) begin
      rRd   <= xRd;
      rData <= aluRes;
   end

   assert property (@(posedge clk) disable iff (!arstN) xValid |-> !$isunknown({opA, opB}));

endmodule

`default_nettype wire

// ==== result.sv ====
// result stage
// holds the write-back, drives the register write port and forwarding path,
// reports each write-back once the register file holds it
`timescale 1ns/1ps
`default_nettype none

module result (
   input  logic             clk,
   input  logic             arstN,
   input  logic             rValid,
   input  logic             rRegWrt,
   input  procPkg::regIdx_t rRd,
   input  procPkg::word_t   rData,
   input  logic             rHalt,
   output logic             wEn,
   output procPkg::regIdx_t wReg,
   output procPkg::word_t   wData,
   output logic             fwdEn,
   output procPkg::regIdx_t fwdReg,
   output procPkg::word_t   fwdData,
   output logic             wbEn,
   output procPkg::regIdx_t wbReg,
   output procPkg::word_t   wbData,
   output logic             halted
);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         wEn    <= 1'b0;
         wbEn   <= 1'b0;
         halted <= 1'b0;
      end else begin
         wEn    <= rValid && rRegWrt;
         wbEn   <= wEn;
         halted <= halted || (rValid && rHalt);
      end
   end

   // report follows the write port by one edge, when the register is updated
   always_ff @(posedge clk) begin
      wReg   <= rRd;
      wData  <= rData;
      wbReg  <= wReg;
      wbData <= wData;
   end

   // forwarding uses the same registers as the write port
   assign fwdEn   = wEn;
   assign fwdReg  = wReg;
   assign fwdData = wData;

   assert property (@(posedge clk) disable iff (!arstN) $past(halted) |-> !wbEn);

endmodule

`default_nettype wire

// ==== proc.sv ====
// top level of the three-stage pipeline
// chains decode, execute and result and exposes the write-back report
`timescale 1ns/1ps
`default_nettype none

module proc (
   input  logic             clk,
   input  logic             arstN,
   input  logic             instrValid,
   input  procPkg::word_t   instr,
   output logic             wbEn,
   output procPkg::regIdx_t wbReg,
   output procPkg::word_t   wbData,
   output logic             halted,
   output logic             err
);

   // decode to execute
   logic             xValid, xUsesA, xUsesB, xUseImm, xRegWrt, xHalt;
   procPkg::aluOp_t  xOp;
   procPkg::word_t   xA, xB, xImm;
   procPkg::regIdx_t xSrcA, xSrcB, xRd;

   // execute to result
   logic             rValid, rRegWrt, rHalt;
   procPkg::regIdx_t rRd;
   procPkg::word_t   rData;

   // result back to decode and execute
   logic             wEn, fwdEn;
   procPkg::regIdx_t wReg, fwdReg;
   procPkg::word_t   wData, fwdData;

   decode decodeStage (
      .clk (clk), .arstN (arstN), .instrValid (instrValid), .instr (instr),
      .wEn (wEn), .wReg (wReg), .wData (wData),
      .xValid (xValid), .xOp (xOp), .xA (xA), .xB (xB),
      .xSrcA (xSrcA), .xSrcB (xSrcB), .xUsesA (xUsesA), .xUsesB (xUsesB),
      .xImm (xImm), .xUseImm (xUseImm), .xRegWrt (xRegWrt), .xRd (xRd),
      .xHalt (xHalt), .err (err)
   );

   execute executeStage (
      .clk (clk), .arstN (arstN),
      .xValid (xValid), .xOp (xOp), .xA (xA), .xB (xB),
      .xSrcA (xSrcA), .xSrcB (xSrcB), .xUsesA (xUsesA), .xUsesB (xUsesB),
      .xImm (xImm), .xUseImm (xUseImm), .xRegWrt (xRegWrt), .xRd (xRd),
      .xHalt (xHalt), .fwdEn (fwdEn), .fwdReg (fwdReg), .fwdData (fwdData),
      .rValid (rValid), .rRegWrt (rRegWrt), .rRd (rRd), .rData (rData),
      .rHalt (rHalt)
   );

   result resultStage (
      .clk (clk), .arstN (arstN),
      .rValid (rValid), .rRegWrt (rRegWrt), .rRd (rRd), .rData (rData),
      .rHalt (rHalt),
      .wEn (wEn), .wReg (wReg), .wData (wData),
      .fwdEn (fwdEn), .fwdReg (fwdReg), .fwdData (fwdData),
      .wbEn (wbEn), .wbReg (wbReg), .wbData (wbData), .halted (halted)
   );

endmodule

`default_nettype wire

// ==== procTb.sv ====
// testbench for the three-stage pipeline
// drives instruction streams, predicts each write-back with a reference model
// and checks order, register, data and latency of every write-back
`timescale 1ns/1ps
`default_nettype none

module procTb;

   localparam int ClkPeriod   = 4;
   localparam int ResetCycles = 5;
   localparam int NumRandom   = 200;
   localparam int MaxGap      = 3;
   localparam int DrainCycles = 8;
   localparam int NumTests    = 6;
   // issue and idle slots of all directed tests, rounded up
   localparam int FixedSlots  = 120;
   localparam int BudgetCycles = ResetCycles + FixedSlots + NumRandom * (MaxGap + 1)
                                 + NumTests * DrainCycles + 50;

   logic             clk;
   logic             arstN;
   logic             instrValid;
   procPkg::word_t   instr;
   logic             wbEn;
   procPkg::regIdx_t wbReg;
   procPkg::word_t   wbData;
   logic             halted;
   logic             err;

   // model state and expected write-backs in program order
   procPkg::word_t   model [8];
   procPkg::regIdx_t expReg [$];
   procPkg::word_t   expData [$];
   int               expCycle [$];
   logic             modelStopped = 1'b0;
   logic             expErr = 1'b0;
   int               cycle = 0;
   string            testName = "reset";

   proc uut (
      .clk        (clk),
      .arstN      (arstN),
      .instrValid (instrValid),
      .instr      (instr),
      .wbEn       (wbEn),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .halted     (halted),
      .err        (err)
   );

   always #(ClkPeriod / 2) clk = ~clk;

   always @(posedge clk) cycle <= cycle + 1;

   task automatic checkVal(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Fail %s expected %0h actual %0h", name, expected, actual);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   // returns 1 when the instruction writes rd, with the value it writes
   function automatic logic refModel(input procPkg::word_t regsIn [8],
                                     input procPkg::word_t ins,
                                     output procPkg::regIdx_t rd,
                                     output procPkg::word_t val);
      logic [3:0]     opc;
      procPkg::word_t a, b, imm6, imm8;
      logic           writes;
      opc    = ins[procPkg::OpcodeHi:procPkg::OpcodeLo];
      rd     = ins[procPkg::RdHi:procPkg::RdLo];
      a      = regsIn[ins[procPkg::RsHi:procPkg::RsLo]];
      b      = regsIn[ins[procPkg::RtHi:procPkg::RtLo]];
      imm6   = {{10{ins[procPkg::Imm6Hi]}}, ins[procPkg::Imm6Hi:procPkg::Imm6Lo]};
      imm8   = {{8{ins[procPkg::Imm8Hi]}}, ins[procPkg::Imm8Hi:procPkg::Imm8Lo]};
      writes = 1'b1;
      case (opc)
         procPkg::opAdd:  val = a + b;
         procPkg::opSub:  val = a - b;
         procPkg::opAnd:  val = a & b;
         procPkg::opXor:  val = a ^ b;
         procPkg::opSll:  val = a << b[3:0];
         procPkg::opAddi: val = a + imm6;
         procPkg::opLbi:  val = imm8;
         default: begin
            val    = '0;
            writes = 1'b0;
         end
      endcase
      return writes;
   endfunction

   // nothing counts once a HALT has been issued
   task automatic applyModel(input procPkg::word_t ins);
      logic [3:0]       opc;
      procPkg::regIdx_t rd;
      procPkg::word_t   val;
      opc = ins[procPkg::OpcodeHi:procPkg::OpcodeLo];
      if (!modelStopped) begin
         if (opc == procPkg::opHalt) begin
            modelStopped = 1'b1;
         end else if (opc >= 4'd8) begin
            expErr = 1'b1;
         end else if (refModel(model, ins, rd, val)) begin
            model[rd] = val;
            expReg.push_back(rd);
            expData.push_back(val);
            // sampled at the next edge, reported three edges later
            expCycle.push_back(cycle + 4);
         end
      end
   endtask

   function automatic procPkg::word_t encodeR(input logic [3:0] op, input int rd,
                                              input int rs, input int rt);
      procPkg::word_t ins;
      ins = '0;
      ins[procPkg::OpcodeHi:procPkg::OpcodeLo] = op;
      ins[procPkg::RdHi:procPkg::RdLo]         = 3'(rd);
      ins[procPkg::RsHi:procPkg::RsLo]         = 3'(rs);
      ins[procPkg::RtHi:procPkg::RtLo]         = 3'(rt);
      return ins;
   endfunction

   function automatic procPkg::word_t encodeI(input logic [3:0] op, input int rd,
                                              input int rs, input int imm);
      procPkg::word_t ins;
      ins = '0;
      ins[procPkg::OpcodeHi:procPkg::OpcodeLo] = op;
      ins[procPkg::RdHi:procPkg::RdLo]         = 3'(rd);
      ins[procPkg::RsHi:procPkg::RsLo]         = 3'(rs);
      ins[procPkg::Imm6Hi:procPkg::Imm6Lo]     = 6'(imm);
      return ins;
   endfunction

   function automatic procPkg::word_t encodeLbi(input int rd, input int imm);
      procPkg::word_t ins;
      ins = '0;
      ins[procPkg::OpcodeHi:procPkg::OpcodeLo] = procPkg::opLbi;
      ins[procPkg::RdHi:procPkg::RdLo]         = 3'(rd);
      ins[procPkg::Imm8Hi:procPkg::Imm8Lo]     = 8'(imm);
      return ins;
   endfunction

   task automatic issue(input procPkg::word_t ins);
      @(posedge clk);
      #1;
      instrValid = 1'b1;
      instr      = ins;
      applyModel(ins);
   endtask

   // instr keeps changing while invalid, decode must ignore it
   task automatic idleCycle();
      @(posedge clk);
      #1;
      instrValid = 1'b0;
      instr      = 16'($urandom);
   endtask

   task automatic endTest();
      repeat (DrainCycles) idleCycle();
      if (expReg.size() != 0) begin
         $display("%0d write-backs never arrived in test %s", expReg.size(), testName);
         $display("Verification failed");
         $fatal(1);
      end else begin
         checkVal({testName, " err"}, 32'(expErr), 32'(err));
      end
   endtask

   // one write-back per cycle with wbEn high
   always @(negedge clk) begin
      if (arstN && wbEn) begin
         if (expReg.size() == 0) begin
            $display("unexpected write-back to r%0d with data %h in test %s",
                     wbReg, wbData, testName);
            $display("Verification failed");
            $fatal(1);
         end else begin
            checkVal({testName, " latency"}, 32'(expCycle.pop_front()), 32'(cycle));
            checkVal({testName, " wbReg"}, 32'(expReg.pop_front()), 32'(wbReg));
            checkVal({testName, " wbData"}, 32'(expData.pop_front()), 32'(wbData));
         end
      end
   end

   initial begin
      #(BudgetCycles * ClkPeriod);
      $display("timeout, the run did not end within %0d cycles", BudgetCycles);
      $display("Verification failed");
      $fatal(1);
   end

   initial begin
      int             gap;
      procPkg::word_t ins;
      void'($urandom(57));
      clk        = 1'b0;
      arstN      = 1'b0;
      instrValid = 1'b0;
      instr      = '0;
      for (int r = 0; r < 8; r++) begin
         model[r] = '0;
      end
      repeat (ResetCycles) @(posedge clk);
      #1;
      arstN = 1'b1;

      @(negedge clk);
      checkVal("reset wbEn", 0, 32'(wbEn));
      checkVal("reset halted", 0, 32'(halted));
      checkVal("reset err", 0, 32'(err));
      issue(encodeR(procPkg::opAdd, 1, 2, 3));
      issue(encodeLbi(4, 5));
      issue(encodeR(procPkg::opAdd, 5, 4, 6));
      issue(encodeR(procPkg::opXor, 6, 7, 0));
      endTest();

      testName = "directed";
      issue(encodeLbi(1, -3));
      issue(encodeLbi(2, 127));
      issue(encodeLbi(3, -128));
      issue(encodeR(procPkg::opAdd, 4, 1, 2));
      issue(encodeR(procPkg::opSub, 5, 3, 2));
      issue(encodeR(procPkg::opSub, 6, 2, 3));
      issue(encodeR(procPkg::opAnd, 7, 1, 3));
      issue(encodeR(procPkg::opXor, 0, 1, 2));
      // shift amount comes from the low 4 bits of -3
      issue(encodeR(procPkg::opSll, 4, 2, 1));
      issue(encodeI(procPkg::opAddi, 5, 1, -32));
      issue(encodeI(procPkg::opAddi, 6, 2, 31));
      issue(encodeLbi(1, -1));
      issue(encodeI(procPkg::opAddi, 2, 1, 1));
      issue(encodeLbi(7, 8));
      issue(encodeR(procPkg::opSll, 3, 3, 7));
      issue(encodeR(procPkg::opAdd, 0, 3, 3));
      issue(encodeR(procPkg::opSub, 5, 2, 1));
      issue(encodeR(procPkg::opNop, 6, 6, 6));
      endTest();

      // each instruction reads the rd of the one d places earlier
      testName = "chains";
      for (int d = 1; d <= 3; d++) begin
         for (int i = 8; i < 20; i++) begin
            if (i % 2 == 0) begin
               issue(encodeI(procPkg::opAddi, i, i - d, i));
            end else begin
               issue(encodeR(procPkg::opSub, i, i + 3, i - d));
            end
         end
      end
      endTest();

      testName = "random";
      for (int i = 0; i < NumRandom; i++) begin
         gap = $urandom % (MaxGap + 1);
         repeat (gap) idleCycle();
         ins = 16'($urandom);
         ins[procPkg::OpcodeHi:procPkg::OpcodeLo] = 4'($urandom % 8);
         issue(ins);
      end
      endTest();

      testName = "illegal";
      checkVal("illegal err before", 0, 32'(err));
      issue(encodeLbi(1, 9));
      issue(encodeR(4'd9, 1, 1, 1));
      idleCycle();
      @(negedge clk);
      checkVal("illegal err raised", 1, 32'(err));
      issue(encodeR(procPkg::opAdd, 2, 1, 1));
      issue(encodeR(4'd14, 3, 1, 1));
      issue(encodeI(procPkg::opAddi, 3, 2, -2));
      endTest();

      testName = "halt";
      issue(encodeLbi(3, 7));
      issue(encodeR(procPkg::opAdd, 4, 3, 3));
      issue(encodeR(procPkg::opHalt, 0, 0, 0));
      idleCycle();
      idleCycle();
      @(negedge clk);
      checkVal("halt early", 0, 32'(halted));
      idleCycle();
      @(negedge clk);
      checkVal("halt raised", 1, 32'(halted));
      issue(encodeLbi(5, 1));
      issue(encodeR(procPkg::opAdd, 6, 4, 4));
      issue(encodeR(4'd11, 7, 1, 1));
      endTest();
      checkVal("halt held", 1, 32'(halted));

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
procPkg.sv
regFile.sv
decode.sv
execute.sv
result.sv
proc.sv
procTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the pipeline testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module procTb -f compile.f -o procSim

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/procSim
